//--- verilog/ext_periph_pkg.sv
// External peripheral package
// Bus structs, memcopy register map and RAM geometry for the subsystem

package ext_periph_pkg;

  // One OBI request from a master
  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  // OBI slave answer, gnt and rvalid handshakes
  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
  } obi_resp_t;

  // One register bus access
  typedef struct packed {
    logic        valid;
    logic        write;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } reg_req_t;

  // Register bus response
  typedef struct packed {
    logic        ready;
    logic        error;
    logic [31:0] rdata;
  } reg_rsp_t;

  // Offset bits decoded by the memcopy register file
  localparam int unsigned REG_OFFSET_W = 8;

  // Memcopy register map, one 32-bit word each
  localparam logic [REG_OFFSET_W-1:0] MEMCOPY_SRC_OFFSET    = 8'h00;
  localparam logic [REG_OFFSET_W-1:0] MEMCOPY_DST_OFFSET    = 8'h04;
  localparam logic [REG_OFFSET_W-1:0] MEMCOPY_SIZE_OFFSET   = 8'h08;
  localparam logic [REG_OFFSET_W-1:0] MEMCOPY_STATUS_OFFSET = 8'h0C;

  // STATUS bit positions
  localparam int unsigned STATUS_IDLE_BIT = 0;

  // Slow RAM geometry
  localparam int unsigned RAM_WORDS_DEFAULT = 128;
  localparam int unsigned RAM_ADDR_LSB      = 2;

  // Full word byte enable
  localparam logic [3:0] OBI_BE_WORD = 4'hF;

endpackage

//--- verilog/memcopy_fifo.sv
`timescale 1ns/1ps
// Memcopy FIFO
// Holds words read from the source until they are written out

module memcopy_fifo #(
  parameter int unsigned FifoDepth = 4
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        push_i,
  input  logic [31:0] wdata_i,
  input  logic        pop_i,
  output logic [31:0] rdata_o,
  output logic        empty_o,
  output logic        full_o
);

  localparam int unsigned PtrW = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int unsigned CntW = $clog2(FifoDepth + 1);

  logic [31:0]     mem_q [FifoDepth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            do_push;
  logic            do_pop;

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CntW'(FifoDepth));
  assign do_pop  = pop_i && !empty_o;
  // A pop frees the slot a push needs in the same cycle
  assign do_push = push_i && (!full_o || do_pop);
  assign rdata_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // Pointers wrap since depth is a power of two
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= wdata_i;
    end
  end

endmodule

//--- verilog/obi_arbiter.sv
`timescale 1ns/1ps
// OBI arbiter
// Round-robin between host and DMA masters onto the single RAM port

module obi_arbiter import ext_periph_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  obi_req_t  host_req_i,
  output obi_resp_t host_resp_o,
  input  obi_req_t  dma_req_i,
  output obi_resp_t dma_resp_o,
  output obi_req_t  mem_req_o,
  input  obi_resp_t mem_resp_i
);

  logic sel_dma;
  logic prio_dma_q;
  logic owner_dma_q;

  // Priority bit only matters when both masters request
  always_comb begin
    if (host_req_i.req && dma_req_i.req) begin
      sel_dma = prio_dma_q;
    end else begin
      sel_dma = dma_req_i.req;
    end
  end

  assign mem_req_o = sel_dma ? dma_req_i : host_req_i;

  // Grant goes back to the selected master only
  assign host_resp_o.gnt = mem_resp_i.gnt && !sel_dma;
  assign dma_resp_o.gnt  = mem_resp_i.gnt && sel_dma;

  // Response steered by the owner of last cycle's grant
  assign host_resp_o.rvalid = mem_resp_i.rvalid && !owner_dma_q;
  assign dma_resp_o.rvalid  = mem_resp_i.rvalid && owner_dma_q;
  assign host_resp_o.rdata  = mem_resp_i.rdata;
  assign dma_resp_o.rdata   = mem_resp_i.rdata;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      prio_dma_q  <= 1'b0;
      owner_dma_q <= 1'b0;
    end else if (mem_resp_i.gnt) begin
      // Hand priority to the other master after each grant
      prio_dma_q  <= !sel_dma;
      owner_dma_q <= sel_dma;
    end
  end

endmodule

//--- verilog/slow_memory.sv
`timescale 1ns/1ps
// Slow memory
// Word RAM on an OBI slave port with pseudo-random grant latency

module slow_memory import ext_periph_pkg::*; #(
  parameter int unsigned NumWords    = RAM_WORDS_DEFAULT,
  parameter int unsigned MaxGntDelay = 3
) (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  obi_req_t  obi_req_i,
  output obi_resp_t obi_resp_o
);

  localparam int unsigned AddrW = $clog2(NumWords);

  logic [31:0]      mem_q [NumWords];
  logic [AddrW-1:0] word_addr;
  logic [7:0]       lfsr_q;
  logic [7:0]       dly_q;
  logic             waiting_q;
  logic             rvalid_q;
  logic [31:0]      rdata_q;
  logic [7:0]       dly;
  logic             gnt;

  // Bits below the word offset and above the array are ignored
  assign word_addr = obi_req_i.addr[RAM_ADDR_LSB +: AddrW];

  // Fresh delay for a new request, else the running count
  assign dly = waiting_q ? dly_q : 8'(lfsr_q % (MaxGntDelay + 1));
  assign gnt = obi_req_i.req && (dly == '0);

  assign obi_resp_o.gnt    = gnt;
  assign obi_resp_o.rvalid = rvalid_q;
  assign obi_resp_o.rdata  = rdata_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lfsr_q    <= 8'hA5;
      dly_q     <= '0;
      waiting_q <= 1'b0;
      rvalid_q  <= 1'b0;
    end else begin
      // Taps 8,6,5,4 for a maximal length sequence
      lfsr_q    <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
      rvalid_q  <= gnt;
      waiting_q <= obi_req_i.req && !gnt;
      if (obi_req_i.req && !gnt) begin
        dly_q <= dly - 8'd1;
      end
    end
  end

  // Writes are acknowledged with rvalid as well
  always_ff @(posedge clk_i) begin
    if (gnt) begin
      if (obi_req_i.we) begin
        mem_q[word_addr] <= obi_req_i.wdata;
      end else begin
        rdata_q <= mem_q[word_addr];
      end
    end
  end

endmodule

//--- verilog/memcopy_ctrl.sv
`timescale 1ns/1ps
// Memcopy controller
// Register file plus copy FSM moving words through one OBI master port

module memcopy_ctrl import ext_periph_pkg::*; #(
  parameter int unsigned FifoDepth = 4
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  reg_req_t    reg_req_i,
  output reg_rsp_t    reg_rsp_o,
  output obi_req_t    obi_req_o,
  input  obi_resp_t   obi_resp_i,
  output logic        fifo_push_o,
  output logic [31:0] fifo_wdata_o,
  output logic        fifo_pop_o,
  input  logic [31:0] fifo_rdata_i,
  input  logic        fifo_empty_i,
  output logic        done_intr_o
);

  localparam int unsigned CreditW = $clog2(FifoDepth + 1);

  typedef enum logic {
    ST_IDLE,
    ST_COPY
  } state_e;

  state_e             state_q;
  logic [31:0]        src_q;
  logic [31:0]        dst_q;
  logic [31:0]        rd_addr_q;
  logic [31:0]        wr_addr_q;
  logic [31:0]        rd_left_q;
  logic [31:0]        wr_left_q;
  logic [CreditW-1:0] credit_q;
  obi_req_t           req_q;
  logic               last_rd_q;
  logic               gnt_rd_q;
  logic               done_q;

  logic [REG_OFFSET_W-1:0] offset;
  logic                    idle;
  logic                    reg_wr;
  logic                    wr_src;
  logic                    wr_dst;
  logic                    wr_size;
  logic                    can_load;
  logic                    rd_ok;
  logic                    wr_ok;
  logic                    issue_rd;
  logic                    issue_wr;
  logic                    wr_ack;
  logic                    last_ack;

  assign offset = reg_req_i.addr[REG_OFFSET_W-1:0];
  assign idle   = (state_q == ST_IDLE);
  assign reg_wr = reg_req_i.valid && reg_req_i.write;

  // Register decode, answered in the request cycle
  always_comb begin
    reg_rsp_o.ready = reg_req_i.valid;
    reg_rsp_o.error = 1'b0;
    reg_rsp_o.rdata = '0;
    wr_src          = 1'b0;
    wr_dst          = 1'b0;
    wr_size         = 1'b0;
    case (offset)
      MEMCOPY_SRC_OFFSET: begin
        reg_rsp_o.rdata = src_q;
        wr_src          = reg_wr;
      end
      MEMCOPY_DST_OFFSET: begin
        reg_rsp_o.rdata = dst_q;
        wr_dst          = reg_wr;
      end
      MEMCOPY_SIZE_OFFSET: begin
        // Remaining words of the running copy
        reg_rsp_o.rdata = wr_left_q;
        reg_rsp_o.error = reg_wr && !idle;
        wr_size         = reg_wr && idle;
      end
      MEMCOPY_STATUS_OFFSET: begin
        reg_rsp_o.rdata[STATUS_IDLE_BIT] = idle;
        reg_rsp_o.error                  = reg_wr;
      end
      default: begin
        reg_rsp_o.error = reg_req_i.valid;
      end
    endcase
  end

  // New request may be loaded when the port is free or just granted
  assign can_load = !req_q.req || obi_resp_i.gnt;
  assign rd_ok    = !idle && (rd_left_q != '0) && (credit_q < CreditW'(FifoDepth));
  assign wr_ok    = !idle && !fifo_empty_i;

  // Alternate read and write when both sides are ready
  assign issue_wr = can_load && wr_ok && (last_rd_q || !rd_ok);
  assign issue_rd = can_load && rd_ok && !issue_wr;

  // rvalid kind follows the access granted one cycle before
  assign wr_ack   = obi_resp_i.rvalid && !gnt_rd_q;
  assign last_ack = wr_ack && (wr_left_q == 32'd1);

  assign obi_req_o    = req_q;
  assign fifo_pop_o   = issue_wr;
  assign fifo_push_o  = obi_resp_i.rvalid && gnt_rd_q;
  assign fifo_wdata_o = obi_resp_i.rdata;
  assign done_intr_o  = done_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= ST_IDLE;
      src_q     <= '0;
      dst_q     <= '0;
      rd_addr_q <= '0;
      wr_addr_q <= '0;
      rd_left_q <= '0;
      wr_left_q <= '0;
      credit_q  <= '0;
      req_q     <= '0;
      last_rd_q <= 1'b0;
      gnt_rd_q  <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      done_q   <= 1'b0;
      gnt_rd_q <= obi_resp_i.gnt && req_q.req && !req_q.we;
      if (wr_src) begin
        src_q <= reg_req_i.wdata;
      end
      if (wr_dst) begin
        dst_q <= reg_req_i.wdata;
      end
      if (wr_size) begin
        rd_addr_q <= src_q;
        wr_addr_q <= dst_q;
        rd_left_q <= reg_req_i.wdata;
        wr_left_q <= reg_req_i.wdata;
        if (reg_req_i.wdata == '0) begin
          done_q <= 1'b1;
        end else begin
          state_q <= ST_COPY;
        end
      end
      if (can_load) begin
        req_q.req <= issue_rd || issue_wr;
        req_q.we  <= issue_wr;
        req_q.be  <= OBI_BE_WORD;
        if (issue_wr) begin
          req_q.addr  <= wr_addr_q;
          req_q.wdata <= fifo_rdata_i;
          wr_addr_q   <= wr_addr_q + 32'd4;
          last_rd_q   <= 1'b0;
        end
        if (issue_rd) begin
          req_q.addr <= rd_addr_q;
          rd_addr_q  <= rd_addr_q + 32'd4;
          rd_left_q  <= rd_left_q - 32'd1;
          last_rd_q  <= 1'b1;
        end
      end
      // Credits cover words in flight and words held in the FIFO
      if (issue_rd) begin
        credit_q <= credit_q + 1'b1;
      end else if (issue_wr) begin
        credit_q <= credit_q - 1'b1;
      end
      if (wr_ack) begin
        wr_left_q <= wr_left_q - 32'd1;
      end
      if (last_ack) begin
        state_q <= ST_IDLE;
        done_q  <= 1'b1;
      end
    end
  end

endmodule

//--- verilog/ext_subsys_top.sv
`timescale 1ns/1ps
// External subsystem top
// Memcopy peripheral and host port sharing a slow RAM through an arbiter

module ext_subsys_top import ext_periph_pkg::*; #(
  parameter int unsigned NumWords    = RAM_WORDS_DEFAULT,
  parameter int unsigned FifoDepth   = 4,
  parameter int unsigned MaxGntDelay = 3
) (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  reg_req_t  reg_req_i,
  output reg_rsp_t  reg_rsp_o,
  input  obi_req_t  host_obi_req_i,
  output obi_resp_t host_obi_resp_o,
  output logic      done_intr_o
);

  obi_req_t    dma_obi_req;
  obi_resp_t   dma_obi_resp;
  obi_req_t    mem_obi_req;
  obi_resp_t   mem_obi_resp;
  logic        fifo_push;
  logic [31:0] fifo_wdata;
  logic        fifo_pop;
  logic [31:0] fifo_rdata;
  logic        fifo_empty;

  memcopy_ctrl #(
    .FifoDepth(FifoDepth)
  ) u_memcopy_ctrl (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .reg_req_i   (reg_req_i),
    .reg_rsp_o   (reg_rsp_o),
    .obi_req_o   (dma_obi_req),
    .obi_resp_i  (dma_obi_resp),
    .fifo_push_o (fifo_push),
    .fifo_wdata_o(fifo_wdata),
    .fifo_pop_o  (fifo_pop),
    .fifo_rdata_i(fifo_rdata),
    .fifo_empty_i(fifo_empty),
    .done_intr_o (done_intr_o)
  );

  // Full flag unused, reads are credited by the controller
  memcopy_fifo #(
    .FifoDepth(FifoDepth)
  ) u_memcopy_fifo (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .push_i (fifo_push),
    .wdata_i(fifo_wdata),
    .pop_i  (fifo_pop),
    .rdata_o(fifo_rdata),
    .empty_o(fifo_empty),
    .full_o ()
  );

  obi_arbiter u_obi_arbiter (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .host_req_i (host_obi_req_i),
    .host_resp_o(host_obi_resp_o),
    .dma_req_i  (dma_obi_req),
    .dma_resp_o (dma_obi_resp),
    .mem_req_o  (mem_obi_req),
    .mem_resp_i (mem_obi_resp)
  );

  slow_memory #(
    .NumWords   (NumWords),
    .MaxGntDelay(MaxGntDelay)
  ) u_slow_memory (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .obi_req_i (mem_obi_req),
    .obi_resp_o(mem_obi_resp)
  );

endmodule

//--- testbench/tb_ext_subsys.sv
// Testbench for the external subsystem
// Host OBI traffic, memcopy register accesses and table-driven copies against a RAM model

`timescale 1ns/1ps

module tb_ext_subsys import ext_periph_pkg::*; ();

  localparam int unsigned NUM_WORDS    = 128;
  localparam int unsigned NUM_COPIES   = 5;
  localparam int unsigned GNT_TIMEOUT  = 50;
  localparam int unsigned RSP_TIMEOUT  = 5;
  localparam int unsigned DONE_TIMEOUT = 2000;

  // One copy job, in word units
  typedef struct packed {
    logic [31:0] src;
    logic [31:0] dst;
    logic [31:0] size;
  } copy_entry_t;

  logic        clk;
  logic        rst_n;
  reg_req_t    reg_req;
  reg_rsp_t    reg_rsp;
  obi_req_t    host_req;
  obi_resp_t   host_resp;
  logic        done_intr;
  logic [31:0] model_mem [NUM_WORDS];
  copy_entry_t copy_table [NUM_COPIES];
  int          done_cnt;

  ext_subsys_top #(
    .NumWords   (NUM_WORDS),
    .FifoDepth  (4),
    .MaxGntDelay(3)
  ) u_dut (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .reg_req_i      (reg_req),
    .reg_rsp_o      (reg_rsp),
    .host_obi_req_i (host_req),
    .host_obi_resp_o(host_resp),
    .done_intr_o    (done_intr)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // Counts interrupt pulses so none is missed during host traffic
  always @(negedge clk) begin
    if (!rst_n) begin
      done_cnt <= 0;
    end else if (done_intr) begin
      done_cnt <= done_cnt + 1;
    end
  end

  task automatic stop_on_error();
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_word(input obi_resp_t got, input logic [31:0] exp, input string what);
    if (got.rdata !== exp) begin
      $display("mismatch at %0t: %s read %h, expected %h", $time, what, got.rdata, exp);
      stop_on_error();
    end
  endtask

  task automatic check_reg_rsp(input reg_rsp_t got, input reg_rsp_t exp,
                               input logic [31:0] mask, input string what);
    if (got.ready !== exp.ready || got.error !== exp.error ||
        (got.rdata & mask) !== (exp.rdata & mask)) begin
      $display("mismatch at %0t: %s gave ready %b error %b rdata %h, expected %b %b %h",
               $time, what, got.ready, got.error, got.rdata, exp.ready, exp.error, exp.rdata);
      stop_on_error();
    end
  endtask

  function automatic reg_rsp_t expect_rsp(input logic error, input logic [31:0] rdata);
    reg_rsp_t rsp;
    rsp.ready = 1'b1;
    rsp.error = error;
    rsp.rdata = rdata;
    return rsp;
  endfunction

  // Full OBI transaction on the host port, ends at a falling edge plus 1 ns
  task automatic host_access(input logic we, input int word, input logic [31:0] wdata,
                             output obi_resp_t rsp);
    int cnt;
    @(negedge clk);
    host_req.req   = 1'b1;
    host_req.we    = we;
    host_req.be    = 4'hF;
    host_req.addr  = word * 4;
    host_req.wdata = wdata;
    cnt = 0;
    #1;
    while (!host_resp.gnt) begin
      cnt++;
      if (cnt > GNT_TIMEOUT) begin
        $display("Timed out waiting for the host grant at word %0d", word);
        stop_on_error();
      end
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    host_req = '0;
    cnt = 0;
    #1;
    while (!host_resp.rvalid) begin
      cnt++;
      if (cnt > RSP_TIMEOUT) begin
        $display("Timed out waiting for the host rvalid at word %0d", word);
        stop_on_error();
      end
      @(negedge clk);
      #1;
    end
    rsp = host_resp;
  endtask

  task automatic read_check(input int word);
    obi_resp_t rsp;
    host_access(1'b0, word, 32'h0, rsp);
    check_word(rsp, model_mem[word], $sformatf("host read of word %0d", word));
  endtask

  // Ready and the answer are due in the request cycle
  task automatic reg_access(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                            output reg_rsp_t rsp);
    @(negedge clk);
    reg_req.valid = 1'b1;
    reg_req.write = wr;
    reg_req.addr  = addr;
    reg_req.wdata = wdata;
    reg_req.wstrb = 4'hF;
    #1;
    rsp = reg_rsp;
    @(negedge clk);
    reg_req = '0;
    #1;
  endtask

  task automatic wait_done(input int target);
    int cnt;
    cnt = 0;
    while (done_cnt < target) begin
      cnt++;
      if (cnt > DONE_TIMEOUT) begin
        $display("Timed out waiting for the copy done interrupt");
        stop_on_error();
      end
      @(negedge clk);
      #1;
    end
    if (done_cnt != target) begin
      $display("More than one done interrupt pulse for a single copy");
      stop_on_error();
    end
  endtask

  initial begin
    obi_resp_t   orsp;
    reg_rsp_t    rrsp;
    copy_entry_t ce;
    int          target;
    int          w;
    void'($urandom(32'h7b5167fa));
    reg_req  = '0;
    host_req = '0;
    rst_n    = 1'b0;
    copy_table = '{
      '{32'd0,   32'd64,  32'd8},
      '{32'd16,  32'd80,  32'd5},
      '{32'd8,   32'd50,  32'd0},
      '{32'd24,  32'd100, 32'd12},
      '{32'd112, 32'd120, 32'd4}
    };
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Fill the whole RAM from the host and read it back
    for (int i = 0; i < NUM_WORDS; i++) begin
      model_mem[i] = $urandom;
      host_access(1'b1, i, model_mem[i], orsp);
    end
    for (int i = 0; i < NUM_WORDS; i++) begin
      read_check(i);
    end

    // Register file access
    reg_access(1'b1, 32'(MEMCOPY_SRC_OFFSET), 32'h0000_0120, rrsp);
    check_reg_rsp(rrsp, expect_rsp(1'b0, 32'h0), 32'h0, "SRC write");
    reg_access(1'b0, 32'(MEMCOPY_SRC_OFFSET), 32'h0, rrsp);
    check_reg_rsp(rrsp, expect_rsp(1'b0, 32'h0000_0120), '1, "SRC read");
    reg_access(1'b1, 32'(MEMCOPY_DST_OFFSET), 32'h0000_01A4, rrsp);
    check_reg_rsp(rrsp, expect_rsp(1'b0, 32'h0), 32'h0, "DST write");
    reg_access(1'b0, 32'(MEMCOPY_DST_OFFSET), 32'h0, rrsp);
    check_reg_rsp(rrsp, expect_rsp(1'b0, 32'h0000_01A4), '1, "DST read");
    reg_access(1'b0, 32'h0000_0010, 32'h0, rrsp);
    check_reg_rsp(rrsp, expect_rsp(1'b1, 32'h0), 32'h0, "unknown offset read");
    reg_access(1'b1, 32'(MEMCOPY_STATUS_OFFSET), 32'h1, rrsp);
    check_reg_rsp(rrsp, expect_rsp(1'b1, 32'h0), 32'h0, "STATUS write");
    reg_access(1'b0, 32'(MEMCOPY_STATUS_OFFSET), 32'h0, rrsp);
    check_reg_rsp(rrsp, expect_rsp(1'b0, 32'h1), 32'h1, "STATUS idle read");

    // Copy jobs
    for (int e = 0; e < NUM_COPIES; e++) begin
      ce = copy_table[e];
      reg_access(1'b1, 32'(MEMCOPY_SRC_OFFSET), ce.src * 4, rrsp);
      check_reg_rsp(rrsp, expect_rsp(1'b0, 32'h0), 32'h0, "SRC write");
      reg_access(1'b1, 32'(MEMCOPY_DST_OFFSET), ce.dst * 4, rrsp);
      check_reg_rsp(rrsp, expect_rsp(1'b0, 32'h0), 32'h0, "DST write");
      target = done_cnt + 1;
      reg_access(1'b1, 32'(MEMCOPY_SIZE_OFFSET), ce.size, rrsp);
      check_reg_rsp(rrsp, expect_rsp(1'b0, 32'h0), 32'h0, "SIZE write");
      if (ce.size != 0) begin
        reg_access(1'b0, 32'(MEMCOPY_STATUS_OFFSET), 32'h0, rrsp);
        check_reg_rsp(rrsp, expect_rsp(1'b0, 32'h0), 32'h1, "STATUS busy read");
        reg_access(1'b1, 32'(MEMCOPY_SIZE_OFFSET), 32'd7, rrsp);
        check_reg_rsp(rrsp, expect_rsp(1'b1, 32'h0), 32'h0, "SIZE write while busy");
        // Host traffic competing with the DMA for the RAM
        for (int k = 0; k < 4; k++) begin
          w = $urandom % NUM_WORDS;
          while (w >= ce.dst && w < ce.dst + ce.size) begin
            w = $urandom % NUM_WORDS;
          end
          read_check(w);
        end
      end
      wait_done(target);
      reg_access(1'b0, 32'(MEMCOPY_STATUS_OFFSET), 32'h0, rrsp);
      check_reg_rsp(rrsp, expect_rsp(1'b0, 32'h1), 32'h1, "STATUS read after done");
      for (int k = 0; k < ce.size; k++) begin
        model_mem[ce.dst + k] = model_mem[ce.src + k];
      end
      for (int i = 0; i < NUM_WORDS; i++) begin
        read_check(i);
      end
    end

    $display("No errors");
    $finish;
  end

endmodule

//--- verilog.f
verilog/ext_periph_pkg.sv
verilog/memcopy_fifo.sv
verilog/obi_arbiter.sv
verilog/slow_memory.sv
verilog/memcopy_ctrl.sv
verilog/ext_subsys_top.sv
testbench/tb_ext_subsys.sv
